/* rtl/lut_pkg.sv */
package lut_pkg;

   localparam int LUT_ADDR_W = 10;
   localparam int LUT_DATA_W = 32;
   localparam int CFG_ADDR_W = 4;

   // Width of the generator counts and steps
   localparam int CNT_W = 10;

   typedef struct packed {
      logic [31:0]      ext_addr;
      logic [7:0]       length;
      logic [CNT_W-1:0] iterations;
      logic [CNT_W-1:0] period;
      logic [CNT_W-1:0] duty;
      logic [CNT_W-1:0] shift;
      logic [CNT_W-1:0] incr;
      logic             ping_pong;
   } lut_cfg_t;

   // Register map, one word each
   localparam logic [CFG_ADDR_W-1:0] REG_EXT_ADDR  = 4'd0;
   localparam logic [CFG_ADDR_W-1:0] REG_LENGTH    = 4'd1;
   localparam logic [CFG_ADDR_W-1:0] REG_ITER      = 4'd2;
   localparam logic [CFG_ADDR_W-1:0] REG_PER       = 4'd3;
   localparam logic [CFG_ADDR_W-1:0] REG_DUTY      = 4'd4;
   localparam logic [CFG_ADDR_W-1:0] REG_SHIFT     = 4'd5;
   localparam logic [CFG_ADDR_W-1:0] REG_INCR      = 4'd6;
   localparam logic [CFG_ADDR_W-1:0] REG_PING_PONG = 4'd7;

endpackage

/* rtl/dp_port_if.sv */
`timescale 1ns/100ps

interface dp_port_if import lut_pkg::*; #(
   parameter int ADDR_W = LUT_ADDR_W,
   parameter int DATA_W = LUT_DATA_W
);

   logic [ADDR_W-1:0] addr;
   logic [DATA_W-1:0] wdata;
   logic [DATA_W-1:0] rdata;
   logic              enable;
   logic              write;

   // Side that issues accesses
   modport user (
      output addr, wdata, enable, write,
      input  rdata
   );

   // Memory side
   modport mem (
      input  addr, wdata, enable, write,
      output rdata
   );

endinterface

/* rtl/lut_addr_gen.sv */
`timescale 1ns/100ps

module lut_addr_gen import lut_pkg::*; #(
   parameter int ADDR_W = LUT_ADDR_W
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              run,
   input  lut_cfg_t          cfg,
   output logic              gen_valid,
   input  logic              gen_ready,
   output logic [ADDR_W-1:0] gen_addr,
   output logic              gen_done
);

   logic             busy;
   logic [CNT_W-1:0] step;
   logic [CNT_W-1:0] iter;
   logic             in_duty;
   logic             advance;
   logic             period_end;
   logic             iter_end;
   logic [ADDR_W-1:0] step_incr;

   assign in_duty    = step < cfg.duty;
   assign period_end = step == cfg.period - 1'b1;
   assign iter_end   = iter == cfg.iterations - 1'b1;

   // Steps outside the duty window never wait on the writer
   assign advance   = busy && (!in_duty || gen_ready);
   assign step_incr = in_duty ? ADDR_W'(cfg.incr) : '0;

   assign gen_valid = busy && in_duty;
   assign gen_done  = !busy;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         busy     <= 1'b0;
         step     <= '0;
         iter     <= '0;
         gen_addr <= '0;
      end else if (run) begin
         // An empty pattern finishes at once
         busy     <= (cfg.iterations != '0) && (cfg.period != '0);
         step     <= '0;
         iter     <= '0;
         gen_addr <= '0;
      end else if (advance) begin
         if (period_end) begin
            step     <= '0;
            gen_addr <= gen_addr + step_incr + ADDR_W'(cfg.shift);
            if (iter_end) begin
               busy <= 1'b0;
               iter <= '0;
            end else begin
               iter <= iter + 1'b1;
            end
         end else begin
            step     <= step + 1'b1;
            gen_addr <= gen_addr + step_incr;
         end
      end
   end

endmodule

/* rtl/lut_mem_writer.sv */
`timescale 1ns/100ps

module lut_mem_writer import lut_pkg::*; #(
   parameter int ADDR_W = LUT_ADDR_W,
   parameter int DATA_W = LUT_DATA_W
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              gen_valid,
   output logic              gen_ready,
   input  logic [ADDR_W-1:0] gen_addr,
   input  logic              data_present,
   output logic              data_ready,
   input  logic [DATA_W-1:0] data_in,
   input  logic              bank,
   dp_port_if.user           wr
);

   logic              wr_en_q;
   logic [ADDR_W-1:0] wr_addr_q;
   logic [DATA_W-1:0] wr_data_q;
   logic              xfer;

   assign gen_ready  = data_present;
   assign data_ready = gen_valid;
   assign xfer       = gen_valid && data_present;

   always_ff @(posedge clk or posedge rst) begin
      if (rst)
         wr_en_q <= 1'b0;
      else
         wr_en_q <= xfer;
   end

   // Top address bit picks the bank
   always_ff @(posedge clk) begin
      if (xfer) begin
         wr_addr_q <= {gen_addr[ADDR_W-1] ^ bank, gen_addr[ADDR_W-2:0]};
         wr_data_q <= data_in;
      end
   end

   assign wr.addr   = wr_addr_q;
   assign wr.wdata  = wr_data_q;
   assign wr.enable = wr_en_q;
   assign wr.write  = wr_en_q;

endmodule

/* rtl/lut_dp_ram.sv */
`timescale 1ns/100ps

module lut_dp_ram import lut_pkg::*; #(
   parameter int ADDR_W = LUT_ADDR_W,
   parameter int DATA_W = LUT_DATA_W
) (
   input logic    clk,
   dp_port_if.mem p0,
   dp_port_if.mem p1
);

   localparam int DEPTH = 2 ** ADDR_W;

   logic [DATA_W-1:0] mem [DEPTH];

   // Port 1 wins when both ports write the same word
   always_ff @(posedge clk) begin
      if (p0.enable && p0.write)
         mem[p0.addr] <= p0.wdata;
      if (p1.enable && p1.write)
         mem[p1.addr] <= p1.wdata;
   end

   // Reads return the word held before the edge
   always_ff @(posedge clk) begin
      if (p0.enable)
         p0.rdata <= mem[p0.addr];
   end

   always_ff @(posedge clk) begin
      if (p1.enable)
         p1.rdata <= mem[p1.addr];
   end

endmodule

/* rtl/lut_read_unit.sv */
`timescale 1ns/100ps

module lut_read_unit import lut_pkg::*; #(
   parameter int ADDR_W = LUT_ADDR_W,
   parameter int DATA_W = LUT_DATA_W
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              run,
   input  lut_cfg_t          cfg,
   output logic              databus_valid,
   input  logic              databus_ready,
   output logic [31:0]       databus_addr,
   input  logic [DATA_W-1:0] databus_rdata,
   output logic [7:0]        databus_len,
   input  logic              databus_last,
   output logic              done,
   input  logic [DATA_W-1:0] lookup_in,
   output logic [DATA_W-1:0] lookup_out,
   dp_port_if.user           rd,
   dp_port_if.user           wr
);

   logic              bank_q;
   logic              last_q;
   logic              gen_valid;
   logic              gen_ready;
   logic [ADDR_W-1:0] gen_addr;
   logic              gen_done;
   logic [ADDR_W-1:0] lookup_addr_q;

   assign databus_len = cfg.length;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         bank_q       <= 1'b0;
         databus_addr <= '0;
      end else if (run) begin
         bank_q       <= cfg.ping_pong ? !bank_q : 1'b0;
         databus_addr <= cfg.ext_addr;
      end
   end

   // Done follows the write of the last word
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         done   <= 1'b1;
         last_q <= 1'b0;
      end else begin
         last_q <= !run && databus_valid && databus_ready && databus_last;
         if (run)
            done <= 1'b0;
         else if (last_q || gen_done)
            done <= 1'b1;
      end
   end

   lut_addr_gen #(
      .ADDR_W (ADDR_W)
   ) i_addr_gen (
      .clk       (clk),
      .rst       (rst),
      .run       (run),
      .cfg       (cfg),
      .gen_valid (gen_valid),
      .gen_ready (gen_ready),
      .gen_addr  (gen_addr),
      .gen_done  (gen_done)
   );

   lut_mem_writer #(
      .ADDR_W (ADDR_W),
      .DATA_W (DATA_W)
   ) i_mem_writer (
      .clk          (clk),
      .rst          (rst),
      .gen_valid    (gen_valid),
      .gen_ready    (gen_ready),
      .gen_addr     (gen_addr),
      .data_present (databus_ready),
      .data_ready   (databus_valid),
      .data_in      (databus_rdata),
      .bank         (!bank_q),
      .wr           (wr)
   );

   // Lookup pipe: address register, memory read, output register
   always_ff @(posedge clk) begin
      lookup_addr_q <= {lookup_in[ADDR_W-1] ^ bank_q, lookup_in[ADDR_W-2:0]};
      lookup_out    <= rd.rdata;
   end

   assign rd.addr   = lookup_addr_q;
   assign rd.wdata  = '0;
   assign rd.enable = 1'b1;
   assign rd.write  = 1'b0;

endmodule

/* rtl/lut_config_regs.sv */
`timescale 1ns/100ps

module lut_config_regs import lut_pkg::*; (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  cfg_we,
   input  logic [CFG_ADDR_W-1:0] cfg_addr,
   input  logic [31:0]           cfg_wdata,
   output lut_cfg_t              cfg
);

   // Each field takes the low bits of the written word
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         cfg <= '0;
      end else if (cfg_we) begin
         case (cfg_addr)
            REG_EXT_ADDR: begin
               cfg.ext_addr <= cfg_wdata;
            end
            REG_LENGTH: begin
               cfg.length <= cfg_wdata[7:0];
            end
            REG_ITER: begin
               cfg.iterations <= cfg_wdata[CNT_W-1:0];
            end
            REG_PER: begin
               cfg.period <= cfg_wdata[CNT_W-1:0];
            end
            REG_DUTY: begin
               cfg.duty <= cfg_wdata[CNT_W-1:0];
            end
            REG_SHIFT: begin
               cfg.shift <= cfg_wdata[CNT_W-1:0];
            end
            REG_INCR: begin
               cfg.incr <= cfg_wdata[CNT_W-1:0];
            end
            REG_PING_PONG: begin
               cfg.ping_pong <= cfg_wdata[0];
            end
            default: begin
            end
         endcase
      end
   end

endmodule

/* rtl/lut_top.sv */
`timescale 1ns/100ps

module lut_top import lut_pkg::*; #(
   parameter int ADDR_W = LUT_ADDR_W,
   parameter int DATA_W = LUT_DATA_W
) (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  cfg_we,
   input  logic [CFG_ADDR_W-1:0] cfg_addr,
   input  logic [31:0]           cfg_wdata,
   input  logic                  run,
   output logic                  databus_valid,
   input  logic                  databus_ready,
   output logic [31:0]           databus_addr,
   input  logic [DATA_W-1:0]     databus_rdata,
   output logic [7:0]            databus_len,
   input  logic                  databus_last,
   output logic                  done,
   input  logic [DATA_W-1:0]     lookup_in,
   output logic [DATA_W-1:0]     lookup_out
);

   lut_cfg_t cfg;

   // Port 0 serves lookups, port 1 takes bus words
   dp_port_if #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) lookup_port ();
   dp_port_if #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) write_port ();

   lut_config_regs i_config_regs (
      .clk       (clk),
      .rst       (rst),
      .cfg_we    (cfg_we),
      .cfg_addr  (cfg_addr),
      .cfg_wdata (cfg_wdata),
      .cfg       (cfg)
   );

   lut_read_unit #(
      .ADDR_W (ADDR_W),
      .DATA_W (DATA_W)
   ) i_read_unit (
      .clk           (clk),
      .rst           (rst),
      .run           (run),
      .cfg           (cfg),
      .databus_valid (databus_valid),
      .databus_ready (databus_ready),
      .databus_addr  (databus_addr),
      .databus_rdata (databus_rdata),
      .databus_len   (databus_len),
      .databus_last  (databus_last),
      .done          (done),
      .lookup_in     (lookup_in),
      .lookup_out    (lookup_out),
      .rd            (lookup_port.user),
      .wr            (write_port.user)
   );

   lut_dp_ram #(
      .ADDR_W (ADDR_W),
      .DATA_W (DATA_W)
   ) i_dp_ram (
      .clk (clk),
      .p0  (lookup_port.mem),
      .p1  (write_port.mem)
   );

endmodule

/* tb/tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen #(
   parameter int PERIOD_NS    = 40,
   parameter int RESET_CYCLES = 4
) (
   output logic clk,
   output logic rst
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;
   end

   // Release on a falling edge, clear of the sampling edge
   initial begin
      rst = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
   end

endmodule

/* tb/tb_lut_top.sv */
`timescale 1ns/100ps

module tb_lut_top import lut_pkg::*;;

   localparam int ADDR_W     = LUT_ADDR_W;
   localparam int DATA_W     = LUT_DATA_W;
   localparam int DEPTH      = 1 << ADDR_W;
   localparam int MAX_CYCLES = 4000;

   logic                  clk;
   logic                  rst;
   logic                  cfg_we;
   logic [CFG_ADDR_W-1:0] cfg_addr;
   logic [31:0]           cfg_wdata;
   logic                  run;
   logic                  databus_valid;
   logic                  databus_ready;
   logic [31:0]           databus_addr;
   logic [DATA_W-1:0]     databus_rdata;
   logic [7:0]            databus_len;
   logic                  databus_last;
   logic                  done;
   logic [DATA_W-1:0]     lookup_in;
   logic [DATA_W-1:0]     lookup_out;

   int mismatch_count = 0;
   int failure_count  = 0;
   int cycle_count    = 0;

   // Configuration as last written, and the expected bank state
   logic [31:0] cur_ext;
   int          cur_len;
   int          cur_iter;
   int          cur_period;
   int          cur_duty;
   int          cur_shift;
   int          cur_incr;
   int          cur_pp;
   logic        tb_bank;

   // Expected memory contents, by physical address
   logic [DATA_W-1:0] model_mem [DEPTH];
   bit                model_valid [DEPTH];
   logic [ADDR_W-1:0] pat_addr [$];
   logic [ADDR_W-1:0] look_idx [$];

   tb_clock_gen #(.PERIOD_NS(40), .RESET_CYCLES(4)) i_clock_gen (
      .clk (clk),
      .rst (rst)
   );

   lut_top #(
      .ADDR_W (ADDR_W),
      .DATA_W (DATA_W)
   ) i_lut_top (
      .clk           (clk),
      .rst           (rst),
      .cfg_we        (cfg_we),
      .cfg_addr      (cfg_addr),
      .cfg_wdata     (cfg_wdata),
      .run           (run),
      .databus_valid (databus_valid),
      .databus_ready (databus_ready),
      .databus_addr  (databus_addr),
      .databus_rdata (databus_rdata),
      .databus_len   (databus_len),
      .databus_last  (databus_last),
      .done          (done),
      .lookup_in     (lookup_in),
      .lookup_out    (lookup_out)
   );

   task report_mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
      $display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
      mismatch_count++;
   endtask

   task report_failure(input string msg);
      $display("Error at %0t: %s", $time, msg);
      failure_count++;
   endtask

   task print_counts;
      $display("Mismatches: %0d, other failures: %0d", mismatch_count, failure_count);
   endtask

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= MAX_CYCLES) begin
         $display("Run stopped after %0d cycles without finishing", cycle_count);
         print_counts();
         $display("Simulation failed");
         $finish;
      end
   end

   // Top index bit XOR bank picks the physical bank
   function automatic logic [ADDR_W-1:0] bank_addr(input logic [ADDR_W-1:0] a, input logic b);
      return {a[ADDR_W-1] ^ b, a[ADDR_W-2:0]};
   endfunction

   task write_cfg(input logic [CFG_ADDR_W-1:0] idx, input logic [31:0] value);
      @(negedge clk);
      cfg_we    = 1'b1;
      cfg_addr  = idx;
      cfg_wdata = value;
      @(negedge clk);
      cfg_we = 1'b0;
   endtask

   task configure(input logic [31:0] ext, input int len, input int iters, input int per,
                  input int duty, input int shift, input int incr, input int pp);
      cur_ext    = ext;
      cur_len    = len;
      cur_iter   = iters;
      cur_period = per;
      cur_duty   = duty;
      cur_shift  = shift;
      cur_incr   = incr;
      cur_pp     = pp;
      write_cfg(REG_EXT_ADDR, ext);
      write_cfg(REG_LENGTH, 32'(len));
      write_cfg(REG_ITER, 32'(iters));
      write_cfg(REG_PER, 32'(per));
      write_cfg(REG_DUTY, 32'(duty));
      write_cfg(REG_SHIFT, 32'(shift));
      write_cfg(REG_INCR, 32'(incr));
      write_cfg(REG_PING_PONG, 32'(pp));
   endtask

   task pulse_run;
      @(negedge clk);
      run = 1'b1;
      @(negedge clk);
      run     = 1'b0;
      tb_bank = (cur_pp != 0) ? ~tb_bank : 1'b0;
   endtask

   // Valid steps in order, incr inside the duty window, shift per period
   task build_pattern;
      logic [ADDR_W-1:0] a;
      a = '0;
      pat_addr.delete();
      for (int it = 0; it < cur_iter; it++) begin
         for (int st = 0; st < cur_period; st++) begin
            if (st < cur_duty) begin
               pat_addr.push_back(a);
               a = a + ADDR_W'(cur_incr);
            end
         end
         a = a + ADDR_W'(cur_shift);
      end
   endtask

   task wait_for_done;
      int n;
      n = 0;
      while (done !== 1'b1 && n < 50) begin
         @(negedge clk);
         n++;
      end
      if (done !== 1'b1)
         report_failure("done did not rise after an empty run");
   endtask

   // Bus source, called on a falling edge right after the run pulse
   task feed_words(input logic [31:0] base, input bit stalls);
      logic [ADDR_W-1:0] phys;
      int                sent;
      int                total;
      bit                early_done;
      build_pattern();
      total      = pat_addr.size();
      sent       = 0;
      early_done = 0;
      while (sent < total) begin
         if (done !== 1'b0 && !early_done) begin
            report_failure("done rose before the last word was transferred");
            early_done = 1;
         end
         if (databus_valid && !(stalls && ($urandom % 3 == 0))) begin
            databus_ready = 1'b1;
            databus_rdata = base + sent;
            databus_last  = (sent == total - 1);
            phys = bank_addr(pat_addr[sent], ~tb_bank);
            model_mem[phys]   = base + sent;
            model_valid[phys] = 1'b1;
            sent++;
         end else begin
            databus_ready = 1'b0;
            databus_last  = 1'b0;
         end
         @(negedge clk);
      end
      databus_ready = 1'b0;
      databus_last  = 1'b0;
      if (done !== 1'b0)
         report_mismatch("done", 32'(done), 32'd0);
      @(negedge clk);
      if (done !== 1'b1)
         report_mismatch("done", 32'(done), 32'd1);
   endtask

   task load_table(input logic [31:0] base, input bit stalls);
      pulse_run();
      if (databus_addr !== cur_ext)
         report_mismatch("databus_addr", databus_addr, cur_ext);
      if (databus_len !== 8'(cur_len))
         report_mismatch("databus_len", 32'(databus_len), 32'(cur_len));
      feed_words(base, stalls);
   endtask

   // Pattern of zero iterations, only swaps banks
   task empty_run;
      write_cfg(REG_ITER, 32'd0);
      pulse_run();
      wait_for_done();
      write_cfg(REG_ITER, 32'(cur_iter));
   endtask

   task index_range(input int first, input int count);
      look_idx.delete();
      for (int i = 0; i < count; i++)
         look_idx.push_back(ADDR_W'(first + i));
   endtask

   // One index per cycle, result checked three falling edges later
   task run_lookups;
      logic [DATA_W-1:0] exp_q [$];
      logic [DATA_W-1:0] exp;
      logic [ADDR_W-1:0] phys;
      int                n;
      n = look_idx.size();
      for (int i = 0; i < n + 3; i++) begin
         @(negedge clk);
         if (i >= 3) begin
            exp = exp_q.pop_front();
            if (lookup_out !== exp)
               report_mismatch("lookup_out", lookup_out, exp);
         end
         if (i < n) begin
            lookup_in = DATA_W'(look_idx[i]);
            phys      = bank_addr(look_idx[i], tb_bank);
            if (!model_valid[phys])
               report_failure("lookup of an address that was never loaded");
            exp_q.push_back(model_mem[phys]);
         end
      end
   endtask

   task test_reset;
      if (done !== 1'b1)
         report_mismatch("done", 32'(done), 32'd1);
      if (databus_valid !== 1'b0)
         report_mismatch("databus_valid", 32'(databus_valid), 32'd0);
   endtask

   task test_linear_load;
      configure(32'h8000_1000, 16, 1, 16, 16, 0, 1, 1);
      load_table(32'h1000_0000, 1'b0);
      empty_run();
      index_range(0, 16);
      run_lookups();
   endtask

   task test_strided_load;
      configure(32'h8000_2000, 12, 3, 6, 4, 5, 2, 1);
      load_table(32'h2000_0000, 1'b0);
      empty_run();
      look_idx = pat_addr;
      run_lookups();
   endtask

   task test_backpressure;
      configure(32'h8000_3000, 16, 1, 16, 16, 0, 1, 1);
      load_table(32'h3000_0000, 1'b1);
      empty_run();
      index_range(0, 16);
      run_lookups();
   endtask

   task test_ping_pong_isolation;
      configure(32'h8000_4000, 16, 1, 16, 16, 0, 1, 1);
      empty_run();
      index_range(0, 16);
      pulse_run();
      // Bank 0 keeps serving while bank 1 fills
      fork
         feed_words(32'h4000_0000, 1'b0);
         run_lookups();
      join
      run_lookups();
      empty_run();
      run_lookups();
      write_cfg(REG_PING_PONG, 32'd0);
      cur_pp = 0;
      // Bank 0 after a run from bank 1 and after one from bank 0
      empty_run();
      run_lookups();
      empty_run();
      run_lookups();
   endtask

   task test_lookup_stream;
      logic [ADDR_W-1:0] idx;
      look_idx.delete();
      look_idx.push_back(ADDR_W'(0));
      look_idx.push_back(ADDR_W'(512));
      look_idx.push_back(ADDR_W'(15));
      look_idx.push_back(ADDR_W'(527));
      for (int i = 0; i < 20; i++) begin
         idx = ADDR_W'($urandom % 16);
         if ($urandom % 2 == 1)
            idx[ADDR_W-1] = 1'b1;
         look_idx.push_back(idx);
      end
      run_lookups();
      write_cfg(REG_PING_PONG, 32'd1);
      cur_pp = 1;
      empty_run();
      run_lookups();
   endtask

   initial begin
      cfg_we        = 1'b0;
      cfg_addr      = '0;
      cfg_wdata     = '0;
      run           = 1'b0;
      databus_ready = 1'b0;
      databus_rdata = '0;
      databus_last  = 1'b0;
      lookup_in     = '0;
      tb_bank       = 1'b0;
      void'($urandom(32'h29c0));
      @(negedge clk);
      while (rst)
         @(negedge clk);
      test_reset();
      test_linear_load();
      test_strided_load();
      test_backpressure();
      test_ping_pong_isolation();
      test_lookup_stream();
      print_counts();
      if (mismatch_count == 0 && failure_count == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

/* src.f */
rtl/lut_pkg.sv
rtl/dp_port_if.sv
rtl/lut_addr_gen.sv
rtl/lut_mem_writer.sv
rtl/lut_dp_ram.sv
rtl/lut_read_unit.sv
rtl/lut_config_regs.sv
rtl/lut_top.sv
tb/tb_clock_gen.sv
tb/tb_lut_top.sv

/* run.sh */
#!/bin/bash
# Compile and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --top-module tb_lut_top -f src.f --Mdir obj_dir; then
   echo "Verilator compile failed"
   exit 1
fi

./obj_dir/Vtb_lut_top > sim.log 2>&1
status=$?
cat sim.log

if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "Simulation failed" sim.log; then
   exit 1
fi

exit 0
